// ==== Makefile ====
.PHONY: simulate clean

simulate:
	verilator --binary --assert --timing -Wno-fatal --top-module led_matrix_tb -f led_matrix_top.f -o led_matrix_sim
	./obj_dir/led_matrix_sim | awk '{ print } /All checks passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== led_matrix_top.f ====
logic/led_matrix_pkg.sv
logic/scan_sequencer.sv
logic/frame_buffer.sv
logic/bitplane_select.sv
logic/hub75_driver.sv
logic/led_matrix_top.sv
verification/led_matrix_tb.sv

// ==== logic/bitplane_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitplane_select (
    input  logic                        clk_in,
    input  logic                        reset,
    input  led_matrix_pkg::scan_cmd_t   cmd_in,
    input  led_matrix_pkg::pixel_pair_t pair,
    output led_matrix_pkg::scan_cmd_t   cmd_out,
    output led_matrix_pkg::hub75_data_t bits
);
    import led_matrix_pkg::*;

    // one bit of each channel, weight given by the plane
    always_ff @(posedge clk_in) begin
        bits.r0 <= pair.upper.r[cmd_in.plane];
        bits.g0 <= pair.upper.g[cmd_in.plane];
        bits.b0 <= pair.upper.b[cmd_in.plane];
        bits.r1 <= pair.lower.r[cmd_in.plane];
        bits.g1 <= pair.lower.g[cmd_in.plane];
        bits.b1 <= pair.lower.b[cmd_in.plane];
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            cmd_out <= '0;
        end else begin
            cmd_out <= cmd_in;
        end
    end

    // sequencer wraps the plane before it leaves the channel width
    plane_in_range: assert property (@(posedge clk_in) disable iff (reset)
        cmd_in.plane <= plane_t'(color_bits - 1))
        else $error("plane %0d out of range", cmd_in.plane);

endmodule

`default_nettype wire

// ==== logic/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                        clk_in,
    input  logic                        reset,
    input  logic                        wr_en,
    input  led_matrix_pkg::pix_addr_t   wr_addr,
    input  led_matrix_pkg::pixel_t      wr_data,
    input  led_matrix_pkg::scan_cmd_t   cmd_in,
    output led_matrix_pkg::scan_cmd_t   cmd_out,
    output led_matrix_pkg::pixel_pair_t pair
);
    import led_matrix_pkg::*;

    localparam int depth       = panel_width * half_height;
    localparam int index_width = $clog2(depth);

    // one memory per half, indexed by row then column
    pixel_t                 upper_mem [depth];
    pixel_t                 lower_mem [depth];
    logic                   wr_lower;
    logic [index_width-1:0] wr_index;
    logic [index_width-1:0] rd_index;

    // msb of the host address picks the half
    assign wr_lower = wr_addr[$bits(pix_addr_t) - 1];
    assign wr_index = wr_addr[index_width-1:0];
    assign rd_index = {cmd_in.row, cmd_in.column};

    // host port, takes effect next clock
    always_ff @(posedge clk_in) begin
        if (wr_en && !wr_lower) begin
            upper_mem[wr_index] <= wr_data;
        end
        if (wr_en && wr_lower) begin
            lower_mem[wr_index] <= wr_data;
        end
    end

    // both halves read in the same cycle
    always_ff @(posedge clk_in) begin
        pair.upper <= upper_mem[rd_index];
        pair.lower <= lower_mem[rd_index];
    end

    // command delayed to stay beside its pixels
    always_ff @(posedge clk_in) begin
        if (reset) begin
            cmd_out <= '0;
        end else begin
            cmd_out <= cmd_in;
        end
    end

endmodule

`default_nettype wire

// ==== logic/hub75_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module hub75_driver (
    input  logic                        clk_in,
    input  logic                        reset,
    input  led_matrix_pkg::scan_cmd_t   cmd_in,
    input  led_matrix_pkg::hub75_data_t bits,
    output led_matrix_pkg::hub75_data_t rgb,
    output logic                        pixel_clk,
    output logic                        latch,
    output logic                        oe_n,
    output led_matrix_pkg::row_addr_t   row_address
);
    import led_matrix_pkg::*;

    // shift seen last cycle, clock edge follows the data
    logic clk_pending;

    // data held until the next shift
    always_ff @(posedge clk_in) begin
        if (cmd_in.shift) begin
            rgb <= bits;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            clk_pending <= 1'b0;
            pixel_clk   <= 1'b0;
            latch       <= 1'b0;
            oe_n        <= 1'b1;
            row_address <= '0;
        end else begin
            clk_pending <= cmd_in.shift;
            // rising edge one cycle after rgb settles
            pixel_clk   <= clk_pending;
            latch       <= cmd_in.latch;
            oe_n        <= ~cmd_in.enable;
            // row switches together with the latched data
            if (cmd_in.latch) begin
                row_address <= cmd_in.row;
            end
        end
    end

    // last pixel clock lands before the latch reaches the pins
    clk_latch_apart: assert property (@(posedge clk_in) disable iff (reset)
        !(pixel_clk && latch))
        else $error("pixel_clk and latch high together");

endmodule

`default_nettype wire

// ==== logic/led_matrix_pkg.sv ====
`default_nettype none

package led_matrix_pkg;

    // panel geometry, two halves shifted out side by side
    localparam int panel_width = 64;
    localparam int half_height = 16;
    localparam int color_bits  = 6;

    typedef logic [$clog2(panel_width)-1:0] col_addr_t;
    typedef logic [$clog2(half_height)-1:0] row_addr_t;
    // planes 0 to color_bits-1
    typedef logic [2:0]                     plane_t;
    typedef logic [color_bits-1:0]          color_t;
    // half, row, column from msb down
    typedef logic [10:0]                    pix_addr_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } pixel_t;

    // same column and row in both halves
    typedef struct packed {
        pixel_t upper;
        pixel_t lower;
    } pixel_pair_t;

    // one command per cycle down the pipeline
    typedef struct packed {
        logic      shift;
        col_addr_t column;
        row_addr_t row;
        plane_t    plane;
        logic      latch;
        logic      enable;
    } scan_cmd_t;

    // bits on the panel data pins, 0 is the upper half
    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
    } hub75_data_t;

    typedef enum logic [1:0] {
        shift,
        wait_on,
        latch
    } scan_state_t;

endpackage

`default_nettype wire

// ==== logic/led_matrix_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top #(
    parameter int unsigned base_ticks = 8
) (
    input  logic                        clk_in,
    input  logic                        reset,
    input  logic                        wr_en,
    input  led_matrix_pkg::pix_addr_t   wr_addr,
    input  led_matrix_pkg::pixel_t      wr_data,
    output led_matrix_pkg::hub75_data_t rgb,
    output logic                        pixel_clk,
    output logic                        latch,
    output logic                        oe_n,
    output led_matrix_pkg::row_addr_t   row_address
);
    import led_matrix_pkg::*;

    // one register stage per hop
    scan_cmd_t   cmd_s0;
    scan_cmd_t   cmd_s1;
    pixel_pair_t pair_s1;
    scan_cmd_t   cmd_s2;
    hub75_data_t bits_s2;

    // rows, planes and on-times
    scan_sequencer #(
        .base_ticks(base_ticks)
    ) scan_sequencer_inst (
        .clk_in(clk_in),
        .reset (reset),
        .cmd   (cmd_s0)
    );

    frame_buffer frame_buffer_inst (
        .clk_in (clk_in),
        .reset  (reset),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .cmd_in (cmd_s0),
        .cmd_out(cmd_s1),
        .pair   (pair_s1)
    );

    bitplane_select bitplane_select_inst (
        .clk_in (clk_in),
        .reset  (reset),
        .cmd_in (cmd_s1),
        .pair   (pair_s1),
        .cmd_out(cmd_s2),
        .bits   (bits_s2)
    );

    // panel pins
    hub75_driver hub75_driver_inst (
        .clk_in     (clk_in),
        .reset      (reset),
        .cmd_in     (cmd_s2),
        .bits       (bits_s2),
        .rgb        (rgb),
        .pixel_clk  (pixel_clk),
        .latch      (latch),
        .oe_n       (oe_n),
        .row_address(row_address)
    );

endmodule

`default_nettype wire

// ==== logic/scan_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer #(
    parameter int unsigned base_ticks = 8
) (
    input  logic                      clk_in,
    input  logic                      reset,
    output led_matrix_pkg::scan_cmd_t cmd
);
    import led_matrix_pkg::*;

    // longest on-time belongs to the msb plane
    localparam int unsigned max_ticks = base_ticks << (color_bits - 1);
    localparam int unsigned on_width  = $clog2(max_ticks + 1);

    scan_state_t         state;
    // low half of each column slot carries the shift strobe
    logic                phase;
    col_addr_t           column;
    plane_t              plane;
    row_addr_t           row;
    // remaining lit cycles of the previous plane
    logic [on_width-1:0] on_cnt;
    logic                last_column;
    logic                on_ending;

    // second half of the slot for column 63
    assign last_column = phase && (column == col_addr_t'(panel_width - 1));
    // counter at 1 or 0 means enable is low next cycle
    assign on_ending = on_cnt < on_width'(2);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state  <= shift;
            phase  <= 1'b0;
            column <= '0;
            plane  <= plane_t'(color_bits - 1);
            row    <= '0;
        end else begin
            case (state)
                shift: begin
                    phase <= ~phase;
                    // column wraps to 0 after the last slot
                    if (phase) begin
                        column <= column + col_addr_t'(1);
                    end
                    // skip wait_on when the lit time is already over
                    if (last_column) begin
                        state <= on_ending ? latch : wait_on;
                    end
                end
                wait_on: begin
                    if (on_ending) begin
                        state <= latch;
                    end
                end
                latch: begin
                    // next plane shifts while this one is lit
                    state <= shift;
                    if (plane == '0) begin
                        plane <= plane_t'(color_bits - 1);
                        row   <= row + row_addr_t'(1);
                    end else begin
                        plane <= plane - plane_t'(1);
                    end
                end
                default: begin
                    state <= shift;
                end
            endcase
        end
    end

    // binary weighted on-time, loaded with the plane being latched
    always_ff @(posedge clk_in) begin
        if (reset) begin
            on_cnt <= '0;
        end else if (state == latch) begin
            on_cnt <= on_width'(base_ticks) << plane;
        end else if (on_cnt != '0) begin
            on_cnt <= on_cnt - 1'b1;
        end
    end

    // all fields decoded from registers only
    always_comb begin
        cmd.shift  = (state == shift) && !phase;
        cmd.column = column;
        cmd.row    = row;
        cmd.plane  = plane;
        cmd.latch  = (state == latch);
        cmd.enable = (on_cnt != '0);
    end

    // panel must be dark while its row data changes
    latch_while_dark: assert property (@(posedge clk_in) disable iff (reset)
        !(cmd.latch && cmd.enable))
        else $error("latch raised while enable high");

    // exactly one shift per column between latches
    no_shift_after_last: assert property (@(posedge clk_in) disable iff (reset)
        (cmd.shift && (cmd.column == col_addr_t'(panel_width - 1)))
            |=> (!cmd.shift until cmd.latch))
        else $error("shift after column 63 before latch");

endmodule

`default_nettype wire

// ==== verification/led_matrix_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_matrix_tb;
    import led_matrix_pkg::*;

    localparam int unsigned base_ticks = 2;
    localparam int pixel_count   = 2 * panel_width * half_height;
    localparam int rewrite_count = 256;
    // row-plane under 140 cycles, up to one frame of waiting before each checked frame
    localparam int frame_cycles   = half_height * color_bits * 140;
    localparam int timeout_cycles = 4 * frame_cycles + pixel_count + rewrite_count + 1000;

    logic        clk_in;
    logic        reset;
    logic        wr_en;
    pix_addr_t   wr_addr;
    pixel_t      wr_data;
    hub75_data_t rgb;
    logic        pixel_clk;
    logic        latch;
    logic        oe_n;
    row_addr_t   row_address;

    // model copy of both halves
    pixel_t      upper_model [half_height][panel_width];
    pixel_t      lower_model [half_height][panel_width];
    // bits seen at each pixel clock since the last latch
    hub75_data_t row_image [panel_width];
    int          clk_count = 0;
    row_addr_t   exp_row = '0;
    plane_t      exp_plane = plane_t'(color_bits - 1);
    row_addr_t   shown_row = '0;
    // lit run after a latch
    logic        on_run = 1'b0;
    int          on_count = 0;
    int          on_expected = 0;
    logic        checking = 1'b0;
    int          frames_requested = 0;
    int          frames_started = 0;
    int          frames_done = 0;
    int          seq_errors = 0;
    int          data_errors = 0;
    int          enable_errors = 0;
    int          cycle_count = 0;

    led_matrix_top #(
        .base_ticks(base_ticks)
    ) led_matrix_top_inst (
        .clk_in     (clk_in),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rgb        (rgb),
        .pixel_clk  (pixel_clk),
        .latch      (latch),
        .oe_n       (oe_n),
        .row_address(row_address)
    );

    always #20 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic write_pixel(input pix_addr_t addr, input pixel_t value);
        @(negedge clk_in);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= value;
        // half in the msb, then row, then column
        if (addr[10]) begin
            lower_model[addr[9:6]][addr[5:0]] = value;
        end else begin
            upper_model[addr[9:6]][addr[5:0]] = value;
        end
    endtask

    // in order for a full fill, random addresses otherwise
    task automatic write_pixels(input int count, input bit scattered);
        logic [31:0] addr;
        logic [31:0] value;
        for (int i = 0; i < count; i++) begin
            addr  = scattered ? $urandom_range(pixel_count - 1) : i;
            value = $urandom();
            write_pixel(addr[10:0], value[17:0]);
        end
        @(negedge clk_in);
        wr_en <= 1'b0;
    endtask

    // next full frame gets its data checked
    task automatic check_frame();
        int target;
        target = frames_done + 1;
        frames_requested <= frames_requested + 1;
        wait (frames_done == target);
    endtask

    task automatic compare_row();
        hub75_data_t want;
        pixel_t      up;
        pixel_t      lo;
        for (int col = 0; col < panel_width; col++) begin
            up   = upper_model[exp_row][col];
            lo   = lower_model[exp_row][col];
            want = {up.r[exp_plane], up.g[exp_plane], up.b[exp_plane],
                    lo.r[exp_plane], lo.g[exp_plane], lo.b[exp_plane]};
            assert (row_image[col] === want) else begin
                data_errors++;
                $display("error at %0t: row %0d plane %0d column %0d shows %b, expected %b",
                         $time, exp_row, exp_plane, col, row_image[col], want);
            end
        end
    endtask

    task automatic handle_latch();
        assert (clk_count == panel_width) else begin
            seq_errors++;
            $display("error at %0t: %0d pixel clocks before latch, expected %0d",
                     $time, clk_count, panel_width);
        end
        assert (oe_n === 1'b1 && !on_run) else begin
            enable_errors++;
            $display("error at %0t: panel lit at latch", $time);
        end
        if (checking) begin
            compare_row();
        end
        // row 15 plane 0 closes a frame
        if (exp_row == row_addr_t'(half_height - 1) && exp_plane == '0) begin
            if (checking) begin
                frames_done++;
            end
            checking = frames_started < frames_requested;
            if (checking) begin
                frames_started++;
            end
        end
        shown_row   = exp_row;
        on_run      = 1'b1;
        on_count    = 0;
        on_expected = base_ticks << exp_plane;
        clk_count   = 0;
        // msb plane first, row steps after plane 0
        if (exp_plane == '0) begin
            exp_plane = plane_t'(color_bits - 1);
            exp_row   = exp_row + row_addr_t'(1);
        end else begin
            exp_plane = exp_plane - plane_t'(1);
        end
    endtask

    task automatic track_on_time();
        if (on_run && oe_n === 1'b0) begin
            on_count++;
        end else if (on_run) begin
            assert (on_count == on_expected) else begin
                enable_errors++;
                $display("error at %0t: oe_n low for %0d cycles, expected %0d",
                         $time, on_count, on_expected);
            end
            on_run = 1'b0;
        end else begin
            assert (oe_n === 1'b1) else begin
                enable_errors++;
                $display("error at %0t: oe_n low outside the on-time", $time);
            end
        end
    endtask

    // panel model, outputs settled half a period after the edge
    always @(negedge clk_in) begin
        if (!reset) begin
            assert (!(pixel_clk === 1'b1 && latch === 1'b1)) else begin
                seq_errors++;
                $display("error at %0t: pixel_clk and latch high together", $time);
            end
            if (pixel_clk === 1'b1) begin
                if (clk_count < panel_width) begin
                    row_image[clk_count] = rgb;
                end
                clk_count++;
            end
            if (latch === 1'b1) begin
                handle_latch();
            end else begin
                track_on_time();
            end
            assert (row_address === shown_row) else begin
                seq_errors++;
                $display("error at %0t: row_address %0d, expected %0d",
                         $time, row_address, shown_row);
            end
        end
    end

    initial begin
        void'($urandom(32'he7ea));
        clk_in  = 1'b0;
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (10) @(negedge clk_in);
        reset <= 1'b0;
        write_pixels(pixel_count, 1'b0);
        check_frame();
        // new values must show up in the second checked frame
        write_pixels(rewrite_count, 1'b1);
        check_frame();
        @(negedge clk_in);
        $display("errors: sequence %0d, data %0d, enable %0d",
                 seq_errors, data_errors, enable_errors);
        if (seq_errors + data_errors + enable_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
